//--- hw/gpio_pkg.sv
// ------------------------------
// gpio lite shared definitions
// bus widths, register map, pin limit
// ------------------------------

`default_nettype none

package gpio_pkg;

   // ------------------------------
   // apb bus widths
   // ------------------------------
   localparam int unsigned apb_addr_w = 6;    // paddr, byte offsets
   localparam int unsigned apb_data_w = 32;   // pwdata / prdata

   // ------------------------------
   // pin limit and register word
   // ------------------------------
   localparam int unsigned max_pins   = 16;        // widest supported block
   localparam int unsigned reg_data_w = max_pins;  // internal register word

   // ------------------------------
   // register map, byte offsets
   // ------------------------------
   // dir: 1 = output, 0 = input
   localparam logic [apb_addr_w-1:0] reg_dir      = 6'h00;
   localparam logic [apb_addr_w-1:0] reg_out      = 6'h04;  // output data
   localparam logic [apb_addr_w-1:0] reg_in       = 6'h08;  // synced pin value, ro
   localparam logic [apb_addr_w-1:0] reg_int_mask = 6'h0C;  // 1 = irq enabled
   // 1 = rising, 0 = falling
   localparam logic [apb_addr_w-1:0] reg_int_pol  = 6'h10;
   // sticky, write 1 clears
   localparam logic [apb_addr_w-1:0] reg_int_stat = 6'h14;

   // anything else in the window reads 0
   // and ignores writes

endpackage

`default_nettype wire

//--- hw/gpio_in_sync.sv
// ------------------------------
// gpio input synchronizer
// two flops plus delayed copy for edges
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module gpio_in_sync #(
   parameter int unsigned num_pins = 16
) (
   input  wire                 pclk,
   input  wire                 rst_n,
   input  wire [num_pins-1:0]  pin_in,    // async pin level
   output logic [num_pins-1:0] in_sync,   // second stage
   output logic [num_pins-1:0] in_prev    // in_sync one cycle late
);

   logic [num_pins-1:0] meta;   // first stage, may go metastable

   always_ff @(posedge pclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         meta    <= '0;
         in_sync <= '0;
         in_prev <= '0;
      end
      else
      begin
         meta    <= pin_in;
         in_sync <= meta;      // safe to use from here on
         in_prev <= in_sync;   // edge reference
      end
   end

endmodule

`default_nettype wire

//--- hw/gpio_irq.sv
// ------------------------------
// gpio interrupt unit
// edge detect, sticky status, masking
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module gpio_irq #(
   parameter int unsigned num_pins = 16
) (
   input  wire                 pclk,
   input  wire                 rst_n,
   input  wire [num_pins-1:0]  in_sync,
   input  wire [num_pins-1:0]  in_prev,
   input  wire [num_pins-1:0]  int_pol,    // 1 rising, 0 falling
   input  wire [num_pins-1:0]  int_mask,   // 1 passes status to irq
   input  wire [num_pins-1:0]  stat_clr,   // w1c pulse
   output logic [num_pins-1:0] int_stat,
   output logic [num_pins-1:0] interrupt
);

   logic [num_pins-1:0] rise;
   logic [num_pins-1:0] fall;
   logic [num_pins-1:0] edge_hit;   // edge of selected polarity

   // ------------------------------
   // edge detect
   // ------------------------------
   assign rise     = in_sync & ~in_prev;
   assign fall     = ~in_sync & in_prev;
   assign edge_hit = (rise & int_pol) | (fall & ~int_pol);

   // sticky status, set beats clear in same cycle
   // sets regardless of mask
   always_ff @(posedge pclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         int_stat <= '0;
      end
      else
      begin
         int_stat <= (int_stat & ~stat_clr) | edge_hit;
      end
   end

   assign interrupt = int_stat & int_mask;   // masked view to top

endmodule

`default_nettype wire

//--- hw/gpio_regs.sv
// ------------------------------
// gpio register file
// dir, out, mask, pol, w1c decode, read capture
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module gpio_regs #(
   parameter int unsigned num_pins = 16
) (
   input  wire                             pclk,
   input  wire                             rst_n,
   input  wire                             read,
   input  wire                             write,
   input  wire [gpio_pkg::apb_addr_w-1:0]  addr,
   input  wire [gpio_pkg::reg_data_w-1:0]  wdata,
   input  wire [num_pins-1:0]              in_sync,    // for reg_in
   input  wire [num_pins-1:0]              int_stat,   // for reg_int_stat
   output logic [gpio_pkg::reg_data_w-1:0] rdata,      // held until next read
   output logic [num_pins-1:0]             dir,
   output logic [num_pins-1:0]             out_data,
   output logic [num_pins-1:0]             int_mask,
   output logic [num_pins-1:0]             int_pol,
   output logic [num_pins-1:0]             stat_clr    // one cycle, per pin
);

   import gpio_pkg::*;

   logic [num_pins-1:0]   wr_bits;   // writable slice of wdata
   logic [reg_data_w-1:0] rd_word;   // mux out, zero above num_pins

   assign wr_bits = wdata[num_pins-1:0];   // upper bits dropped

   // ------------------------------
   // writable registers
   // ------------------------------
   always_ff @(posedge pclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         dir      <= '0;   // all inputs
         out_data <= '0;
         int_mask <= '0;
         int_pol  <= '0;
      end
      else if (write)
      begin
         case (addr)
            reg_dir      : dir      <= wr_bits;
            reg_out      : out_data <= wr_bits;
            reg_int_mask : int_mask <= wr_bits;
            reg_int_pol  : int_pol  <= wr_bits;
            default      : ;   // ro / unmapped, ignore
         endcase
      end
   end

   // w1c pulse to irq unit, only on status writes
   assign stat_clr = (write && (addr == reg_int_stat)) ? wr_bits : '0;

   // ------------------------------
   // read path
   // ------------------------------
   always_comb
   begin
      rd_word = '0;
      case (addr)
         reg_dir      : rd_word[num_pins-1:0] = dir;
         reg_out      : rd_word[num_pins-1:0] = out_data;
         reg_in       : rd_word[num_pins-1:0] = in_sync;
         reg_int_mask : rd_word[num_pins-1:0] = int_mask;
         reg_int_pol  : rd_word[num_pins-1:0] = int_pol;
         reg_int_stat : rd_word[num_pins-1:0] = int_stat;
         default      : rd_word = '0;   // unmapped reads 0
      endcase
   end

   // captured in setup phase, valid through access
   always_ff @(posedge pclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rdata <= '0;
      end
      else if (read)
      begin
         rdata <= rd_word;
      end
   end

endmodule

`default_nettype wire

//--- hw/gpio_lite_subunit.sv
// ------------------------------
// gpio pin-side core
// regs, input sync, irq, pin drive
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module gpio_lite_subunit #(
   parameter int unsigned num_pins = 16
) (
   input  wire                             pclk,
   input  wire                             rst_n,
   input  wire                             read,      // setup phase strobe
   input  wire                             write,     // access phase strobe
   input  wire [gpio_pkg::apb_addr_w-1:0]  addr,
   input  wire [gpio_pkg::reg_data_w-1:0]  wdata,
   input  wire [num_pins-1:0]              pin_in,
   input  wire [num_pins-1:0]              tri_state_enable,
   output logic [gpio_pkg::reg_data_w-1:0] rdata,
   output logic [num_pins-1:0]             interrupt,  // per pin, masked
   output logic [num_pins-1:0]             pin_out,
   output logic [num_pins-1:0]             pin_oe_n
);

   // sync to irq / regs
   logic [num_pins-1:0] in_sync;
   logic [num_pins-1:0] in_prev;
   // register outputs
   logic [num_pins-1:0] dir;
   logic [num_pins-1:0] out_data;
   logic [num_pins-1:0] int_mask;
   logic [num_pins-1:0] int_pol;
   // status loop between regs and irq
   logic [num_pins-1:0] int_stat;
   logic [num_pins-1:0] stat_clr;

   // ------------------------------
   // pin drive
   // ------------------------------
   assign pin_out  = out_data;
   // float when input or tri-stated
   assign pin_oe_n = ~dir | tri_state_enable;

   gpio_in_sync #(.num_pins(num_pins)) i_gpio_in_sync (
      .pclk    (pclk),
      .rst_n   (rst_n),
      .pin_in  (pin_in),
      .in_sync (in_sync),
      .in_prev (in_prev)
   );

   gpio_regs #(.num_pins(num_pins)) i_gpio_regs (
      .pclk     (pclk),
      .rst_n    (rst_n),
      .read     (read),
      .write    (write),
      .addr     (addr),
      .wdata    (wdata),
      .in_sync  (in_sync),
      .int_stat (int_stat),
      .rdata    (rdata),
      .dir      (dir),
      .out_data (out_data),
      .int_mask (int_mask),
      .int_pol  (int_pol),
      .stat_clr (stat_clr)
   );

   gpio_irq #(.num_pins(num_pins)) i_gpio_irq (
      .pclk      (pclk),
      .rst_n     (rst_n),
      .in_sync   (in_sync),
      .in_prev   (in_prev),
      .int_pol   (int_pol),
      .int_mask  (int_mask),
      .stat_clr  (stat_clr),
      .int_stat  (int_stat),
      .interrupt (interrupt)
   );

endmodule

`default_nettype wire

//--- hw/gpio_lite.sv
// ------------------------------
// gpio lite top level
// apb slave for up to 16 pins, one irq line
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module gpio_lite #(
   parameter int unsigned num_pins = 16              // pins in use, 1..16
) (
   input  wire                             pclk,     // apb clock
   input  wire                             rst_n,    // async, active low
   // apb slave
   input  wire                             psel,
   input  wire                             penable,
   input  wire                             pwrite,
   input  wire [gpio_pkg::apb_addr_w-1:0]  paddr,
   input  wire [gpio_pkg::apb_data_w-1:0]  pwdata,
   output logic [gpio_pkg::apb_data_w-1:0] prdata,
   // pins
   input  wire [num_pins-1:0]              gpio_pin_in,
   input  wire [num_pins-1:0]              tri_state_enable,  // 1 forces pin to float
   output logic [num_pins-1:0]             gpio_pin_out,
   output logic [num_pins-1:0]             n_gpio_pin_oe,     // active low
   output logic                            gpio_int           // combined irq
);

   import gpio_pkg::*;

   logic                  write;       // access phase write
   logic                  read;        // setup phase read
   logic [reg_data_w-1:0] rdata;       // captured read word from core
   logic [num_pins-1:0]   irq_vec;     // per pin masked status

   // ------------------------------
   // apb phase decode
   // ------------------------------
   assign write = psel & penable & pwrite;
   // read fires in setup so prdata is ready for access
   assign read  = psel & ~penable & ~pwrite;

   // upper half of prdata always zero
   assign prdata = {{(apb_data_w-reg_data_w){1'b0}}, rdata};

   assign gpio_int = |irq_vec;   // any unmasked pin

   // pin-side core
   gpio_lite_subunit #(
      .num_pins         (num_pins)
   ) i_gpio_lite_subunit (
      .pclk             (pclk),
      .rst_n            (rst_n),
      .read             (read),
      .write            (write),
      .addr             (paddr),
      .wdata            (pwdata[reg_data_w-1:0]),   // low half only
      .pin_in           (gpio_pin_in),
      .tri_state_enable (tri_state_enable),
      .rdata            (rdata),
      .interrupt        (irq_vec),
      .pin_out          (gpio_pin_out),
      .pin_oe_n         (n_gpio_pin_oe)
   );

endmodule

`default_nettype wire

//--- dv/gpio_tb.sv
// ------------------------------
// gpio lite testbench
// apb tasks, pattern file runner, random pin test
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module gpio_tb;

   import gpio_pkg::*;

   localparam int unsigned num_pins = 16;
   localparam pattern_path = "dv/gpio_patterns.txt";

   logic                  pclk;
   logic                  rst_n;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [apb_addr_w-1:0] paddr;
   logic [apb_data_w-1:0] pwdata;
   logic [apb_data_w-1:0] prdata;
   logic [num_pins-1:0]   gpio_pin_in;
   logic [num_pins-1:0]   tri_state_enable;
   logic [num_pins-1:0]   gpio_pin_out;
   logic [num_pins-1:0]   n_gpio_pin_oe;
   logic                  gpio_int;

   int check_errors = 0;   // wrong values
   int file_errors  = 0;   // open / parse problems
   int timed_out    = 0;
   int cycle_count  = 0;
   int cycle_limit  = 0;   // 0 = watchdog not armed yet

   gpio_lite #(.num_pins(num_pins)) uut (
      .pclk             (pclk),
      .rst_n            (rst_n),
      .psel             (psel),
      .penable          (penable),
      .pwrite           (pwrite),
      .paddr            (paddr),
      .pwdata           (pwdata),
      .prdata           (prdata),
      .gpio_pin_in      (gpio_pin_in),
      .tri_state_enable (tri_state_enable),
      .gpio_pin_out     (gpio_pin_out),
      .n_gpio_pin_oe    (n_gpio_pin_oe),
      .gpio_int         (gpio_int)
   );

   initial
   begin
      pclk = 1'b0;
      forever #4 pclk = ~pclk;   // 8 ns period
   end

   // ------------------------------
   // closing report and watchdog
   // ------------------------------
   task automatic finish_run;
      $display("errors: checks %0d, pattern file %0d, timeout %0d",
               check_errors, file_errors, timed_out);
      if (check_errors == 0 && file_errors == 0 && timed_out == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   endtask

   always @(posedge pclk)
   begin
      cycle_count++;
      if (cycle_limit != 0 && cycle_count >= cycle_limit)
      begin
         $display("timeout: run stopped after %0d cycles", cycle_count);
         timed_out = 1;
         finish_run();
      end
   end

   // ------------------------------
   // drive and check helpers
   // ------------------------------
   task automatic step;   // inputs move 1 ns after the edge
      @(posedge pclk);
      #1;
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else
      begin
         $display("[ERROR] time %0t: %s expected %h got %h", $time, name, expected, actual);
         check_errors++;
      end
   endtask

   task automatic apb_write(input logic [apb_addr_w-1:0] addr, input logic [31:0] data);
      step();
      psel    = 1'b1;   // setup
      pwrite  = 1'b1;
      penable = 1'b0;
      paddr   = addr;
      pwdata  = data;
      step();
      penable = 1'b1;   // access phase
      step();           // reg updated on this edge
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [apb_addr_w-1:0] addr, output logic [31:0] data);
      step();
      psel    = 1'b1;
      pwrite  = 1'b0;
      penable = 1'b0;
      paddr   = addr;   // capture on next edge
      step();
      penable = 1'b1;
      @(negedge pclk);
      data = prdata;    // mid access phase
      step();
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic read_check(input logic [apb_addr_w-1:0] addr, input logic [15:0] expected);
      logic [31:0] data;
      apb_read(addr, data);
      // upper half must be 0
      check_value($sformatf("prdata @%h", addr), {16'h0000, expected}, data);
   endtask

   task automatic check_pins(input logic [15:0] exp_out, input logic [15:0] exp_oe_n);
      @(negedge pclk);
      check_value("gpio_pin_out", {16'h0000, exp_out}, {16'h0000, gpio_pin_out});
      check_value("n_gpio_pin_oe", {16'h0000, exp_oe_n}, {16'h0000, n_gpio_pin_oe});
   endtask

   // ------------------------------
   // pattern file
   // ------------------------------
   task automatic count_lines(output int lines);
      int fd;
      logic [1023:0] text;
      lines = 0;
      fd = $fopen(pattern_path, "r");
      if (fd != 0)
      begin
         while ($fgets(text, fd) > 0)
            lines++;
         $fclose(fd);
      end
   endtask

   task automatic apply_op(input logic [63:0] op, input logic [31:0] a, input logic [31:0] b);
      case (op)
         "W": apb_write(a[apb_addr_w-1:0], b);
         "R": read_check(a[apb_addr_w-1:0], b[15:0]);
         "P":
         begin
            step();
            gpio_pin_in = a[15:0];
         end
         "T":
         begin
            step();
            tri_state_enable = a[15:0];
         end
         "O": check_pins(a[15:0], b[15:0]);
         "I":
         begin
            @(negedge pclk);
            check_value("gpio_int", {31'h0, a[0]}, {31'h0, gpio_int});
         end
         "C": repeat (a) step();
         default: ;
      endcase
   endtask

   task automatic run_patterns;
      int fd;
      int need;
      int got;
      int entry;
      logic [63:0] op;
      logic [31:0] a;
      logic [31:0] b;
      logic [1023:0] rest;
      entry = 0;
      fd = $fopen(pattern_path, "r");
      if (fd == 0)
      begin
         $display("could not open pattern file %s", pattern_path);
         file_errors++;
      end
      else
      begin
         while ($fscanf(fd, "%s", op) == 1)
         begin
            entry++;
            a = '0;
            b = '0;
            case (op)
               "#": need = 0;   // comment line
               "W", "R", "O": need = 2;
               "P", "T", "I", "C": need = 1;
               default: need = -1;
            endcase
            if (need < 0)
            begin
               $display("pattern entry %0d has an unknown opcode, line skipped", entry);
               file_errors++;
               void'($fgets(rest, fd));
            end
            else if (need == 0)
               void'($fgets(rest, fd));
            else
            begin
               got = (need == 2) ? $fscanf(fd, "%h %h", a, b) : $fscanf(fd, "%h", a);
               if (got != need)
               begin
                  $display("pattern entry %0d could not be parsed", entry);
                  file_errors++;
               end
               else
                  apply_op(op, a, b);
            end
         end
         $fclose(fd);
      end
   endtask

   // random out dir and tri values checked against the oe rule
   task automatic random_pins;
      logic [31:0] rnd;
      logic [15:0] out_v;
      logic [15:0] dir_v;
      logic [15:0] tri_v;
      repeat (20)
      begin
         rnd   = $urandom();
         out_v = rnd[15:0];
         rnd   = $urandom();
         dir_v = rnd[15:0];
         rnd   = $urandom();
         tri_v = rnd[15:0];
         step();
         tri_state_enable = tri_v;
         apb_write(reg_out, {16'h0000, out_v});
         apb_write(reg_dir, {16'h0000, dir_v});
         check_pins(out_v, ~(dir_v & ~tri_v));   // driven only when output and not floated
      end
   endtask

   initial
   begin
      int lines;
      rst_n            = 1'b0;
      psel             = 1'b0;
      penable          = 1'b0;
      pwrite           = 1'b0;
      paddr            = '0;
      pwdata           = '0;
      gpio_pin_in      = '0;
      tri_state_enable = '0;
      void'($urandom(32'he91b_b747));   // seeded once
      count_lines(lines);
      cycle_limit = lines * 20 + 20 * 4 + 200;
      repeat (2) @(posedge pclk);
      #1 rst_n = 1'b1;
      run_patterns();
      random_pins();
      finish_run();
   end

endmodule

`default_nettype wire

//--- dv/gpio_patterns.txt
# columns: op arg1 arg2, values in hex, a line starting with # is skipped
# W addr data | R addr exp | P pins | T mask | O out oe_n | I level | C cycles
R 00 0000
R 04 0000
R 08 0000
R 0c 0000
R 10 0000
R 14 0000
O 0000 ffff
I 0
W 00 00ff
W 04 a5c3
R 00 00ff
R 04 a5c3
T 000f
O a5c3 ff0f
R 3c 0000
W 10 0003
W 0c 0001
R 10 0003
P 0007
C 4
R 08 0007
R 14 0003
I 1
W 14 0001
R 14 0002
I 0
R 0c 0001

//--- sim.f
hw/gpio_pkg.sv
hw/gpio_in_sync.sv
hw/gpio_irq.sv
hw/gpio_regs.sv
hw/gpio_lite_subunit.sv
hw/gpio_lite.sv
dv/gpio_tb.sv

//--- Bender.yml
package:
  name: gpio_lite

sources:
  - files:
      - hw/gpio_pkg.sv
      - hw/gpio_in_sync.sv
      - hw/gpio_irq.sv
      - hw/gpio_regs.sv
      - hw/gpio_lite_subunit.sv
      - hw/gpio_lite.sv
  - target: test
    files:
      - dv/gpio_tb.sv
